/* logic/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  // a command is the direction flag, the register address and the write data
  localparam int cmd_width = 12;

  // byte returned by the peripheral after a read command
  localparam int read_width = 8;

  // clk cycles per sclk half period, so sclk runs at clk/10
  localparam int sclk_half_div = 5;

  // the peripheral has eight registers behind the 3-bit address
  localparam int reg_count = 8;

  // bit 11 is the direction flag, set for a write
  typedef struct packed {
    logic       write;
    logic [2:0] addr;
    logic [7:0] data;
  } spi_cmd_t;

  // pins driven by the master toward the peripheral
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_bus_t;

endpackage

`default_nettype wire

/* logic/spi_sclk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_sclk_gen (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  sclk_run,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);
  import spi_pkg::*;

  localparam int half_width = $clog2(sclk_half_div);

  logic [half_width-1:0] half_cnt;
  logic                  toggle;

  // the last cycle of a half period
  assign toggle = sclk_run && (half_cnt == half_width'(sclk_half_div - 1));

  // strobes are registered together with sclk, so they are high in the
  // cycle right after the matching sclk edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt  <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else if (!sclk_run)
    begin
      // idle phase is fixed so every transfer starts the same way
      half_cnt  <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else
    begin
      sclk_rise <= toggle && !sclk;
      sclk_fall <= toggle && sclk;
      if (toggle)
      begin
        half_cnt <= '0;
        sclk     <= ~sclk;
      end
      else
      begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(sclk_rise && sclk_fall))
    else $error("sclk rise and fall strobes high in the same cycle");

  sclk_low_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
    !sclk_run |-> !sclk)
    else $error("sclk high while the divider is stopped");

endmodule

`default_nettype wire

/* logic/spi_xfer_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_xfer_ctrl (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire spi_pkg::spi_cmd_t cmd_in,
  input  wire                   cmd_vld,
  output logic                  cmd_rdy,
  input  wire                   sclk,
  input  wire                   sclk_rise,
  input  wire                   sclk_fall,
  output logic                  sclk_run,
  output spi_pkg::spi_bus_t     spi,
  input  wire                   miso,
  output logic                  read_vld,
  output logic [7:0]            read_data
);
  import spi_pkg::*;

  localparam int bit_total_max = cmd_width + read_width;
  localparam int cnt_width     = $clog2(bit_total_max + 1);
  localparam int dly_width     = $clog2(sclk_half_div);

  typedef enum logic [1:0] {
    st_idle,
    st_lead,
    st_shift,
    st_guard
  } state_t;

  state_t                state;
  spi_cmd_t              cmd_buf;
  logic [cmd_width-1:0]  tx_shift;
  logic [read_width-1:0] rx_shift;
  logic [cnt_width-1:0]  bit_cnt;
  logic [cnt_width-1:0]  bit_total;
  logic [dly_width-1:0]  dly_cnt;
  logic                  cs_n;
  logic                  accept;
  logic                  dly_done;
  logic                  xfer_done;

  assign cmd_rdy = (state == st_idle);
  assign accept  = cmd_vld && cmd_rdy;

  // a write only sends the command, a read adds one byte back
  assign bit_total = cmd_buf.write ? cnt_width'(cmd_width) : cnt_width'(bit_total_max);

  // shared by the lead-in and the guard time, both one sclk half period
  assign dly_done = (dly_cnt == dly_width'(sclk_half_div - 1));

  // the falling edge after the last sampled bit closes the transfer
  assign xfer_done = (state == st_shift) && sclk_fall && (bit_cnt == bit_total);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= st_idle;
      cs_n      <= 1'b1;
      sclk_run  <= 1'b0;
      bit_cnt   <= '0;
      dly_cnt   <= '0;
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        st_idle:
        begin
          if (accept)
          begin
            state   <= st_lead;
            cs_n    <= 1'b0;
            dly_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        st_lead:
        begin
          if (dly_done)
          begin
            state    <= st_shift;
            sclk_run <= 1'b1;
          end
          else
          begin
            dly_cnt <= dly_cnt + 1'b1;
          end
        end
        st_shift:
        begin
          // bit_cnt counts sampled bits, i.e. rising edges seen so far
          if (sclk_rise)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          else if (xfer_done)
          begin
            state    <= st_guard;
            cs_n     <= 1'b1;
            sclk_run <= 1'b0;
            dly_cnt  <= '0;
            if (!cmd_buf.write)
            begin
              read_vld  <= 1'b1;
              read_data <= rx_shift;
            end
          end
        end
        st_guard:
        begin
          if (dly_done)
          begin
            state <= st_idle;
          end
          else
          begin
            dly_cnt <= dly_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  // zero fill drives mosi low once the command has gone out
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_buf  <= cmd_in;
      tx_shift <= cmd_in;
    end
    else if (state == st_shift && sclk_fall)
    begin
      tx_shift <= {tx_shift[cmd_width-2:0], 1'b0};
    end

    if (state == st_shift && sclk_rise && bit_cnt >= cmd_width)
    begin
      rx_shift <= {rx_shift[read_width-2:0], miso};
    end
  end

  assign spi.sclk = sclk;
  assign spi.cs_n = cs_n;
  assign spi.mosi = ~cs_n & tx_shift[cmd_width-1];

  sclk_only_when_selected: assert property (@(posedge clk) disable iff (!rst_n)
    cs_n |-> !sclk_run)
    else $error("sclk divider running while cs_n is high");

  read_vld_for_reads: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> !cmd_buf.write)
    else $error("read_vld raised for a write command");

  busy_while_selected: assert property (@(posedge clk) disable iff (!rst_n)
    !cs_n |-> !cmd_rdy)
    else $error("cmd_rdy high during a transfer");

endmodule

`default_nettype wire

/* logic/spi_cmd_master.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_master (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire spi_pkg::spi_cmd_t          cmd_in,
  input  wire                            cmd_vld,
  output logic                           cmd_rdy,
  output spi_pkg::spi_bus_t              spi,
  input  wire                            miso,
  output logic                           read_vld,
  output logic [spi_pkg::read_width-1:0] read_data
);

  logic sclk_run;
  logic sclk;
  logic sclk_rise;
  logic sclk_fall;

  spi_sclk_gen spi_sclk_gen_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk_run  (sclk_run),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_xfer_ctrl spi_xfer_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .sclk_run  (sclk_run),
    .spi       (spi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

/* testbench/spi_reg_device.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_reg_device (
  input  wire               rst_n,
  input  wire spi_pkg::spi_bus_t spi,
  output logic              miso
);
  import spi_pkg::*;

  logic [7:0]           regs [reg_count];
  logic [cmd_width-1:0] cmd_sr;
  logic [4:0]           rise_cnt;
  logic [7:0]           out_sr;
  logic                 sclk;
  logic                 cs_n;
  spi_cmd_t             cmd;

  assign sclk = spi.sclk;
  assign cs_n = spi.cs_n;
  assign cmd  = cmd_sr;

  // command bits come in on rising sclk, a write lands when cs_n rises
  always @(posedge sclk or posedge cs_n or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < reg_count; i++)
      begin
        regs[i] <= 8'(i * 8'h11 + 8'h05);
      end
      cmd_sr   <= '0;
      rise_cnt <= '0;
    end
    else if (cs_n)
    begin
      if (cmd.write && rise_cnt == 5'(cmd_width))
      begin
        regs[cmd.addr] <= cmd.data;
      end
      rise_cnt <= '0;
    end
    else
    begin
      if (rise_cnt < 5'(cmd_width))
      begin
        cmd_sr <= {cmd_sr[cmd_width-2:0], spi.mosi};
      end
      rise_cnt <= rise_cnt + 5'd1;
    end
  end

  // the read byte goes out on falling sclk, ahead of the rising edge that samples it
  always @(negedge sclk or posedge cs_n or negedge rst_n)
  begin
    if (!rst_n)
    begin
      miso   <= 1'b0;
      out_sr <= '0;
    end
    else if (cs_n)
    begin
      miso <= 1'b0;
    end
    else if (!cmd.write && rise_cnt == 5'(cmd_width))
    begin
      miso   <= regs[cmd.addr][7];
      out_sr <= {regs[cmd.addr][6:0], 1'b0};
    end
    else if (rise_cnt > 5'(cmd_width))
    begin
      miso   <= out_sr[7];
      out_sr <= {out_sr[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_spi_cmd_master.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_spi_cmd_master;
  import spi_pkg::*;

  localparam int num_random     = 24;
  // 40 commands of at most about 230 clk each plus reset, with about double margin
  localparam int timeout_cycles = 20000;
  localparam int ready_limit    = 206 + sclk_half_div;

  logic                  clk = 1'b0;
  logic                  rst_n;
  spi_cmd_t              cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  spi_bus_t              spi;
  logic                  miso;
  logic                  read_vld;
  logic [read_width-1:0] read_data;

  logic [7:0]           shadow [reg_count];
  logic [reg_count-1:0] written = '0;
  logic [7:0]           expect_q [$];
  string                name_q [$];
  logic [7:0]           exp_byte;
  string                exp_name;
  int error_cnt = 0;
  int cycle_cnt = 0;
  int accepted_cnt = 0;
  int read_accepted_cnt = 0;
  int read_vld_cnt = 0;
  int cs_fall_cnt = 0;
  int sclk_rise_cnt = 0;
  int busy_cnt = 0;
  int reads_checked = 0;
  logic cur_write = 1'b0;
  logic read_pending = 1'b0;
  logic busy_track = 1'b0;
  logic sclk_prev = 1'b0;
  logic cs_prev = 1'b1;

  always #10 clk = ~clk;

  spi_cmd_master spi_cmd_master_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .spi       (spi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_reg_device spi_reg_device_inst (
    .rst_n (rst_n),
    .spi   (spi),
    .miso  (miso)
  );

  function automatic logic [7:0] reset_pattern(input int addr);
    return 8'(addr * 8'h11 + 8'h05);
  endfunction

  function automatic spi_cmd_t make_cmd(input logic write, input int addr, input logic [7:0] data);
    spi_cmd_t cmd;
    cmd.write = write;
    cmd.addr  = 3'(addr);
    cmd.data  = data;
    return cmd;
  endfunction

  task automatic note_failure(input string what);
    error_cnt++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic report_mismatch(input string test_name, input int expected, input int actual);
    error_cnt++;
    $display("FAILED %s: expected %0d (0x%0h), actual %0d (0x%0h)",
             test_name, expected, expected, actual, actual);
  endtask

  // waits for cmd_rdy, issues one command and optionally a stray strobe while busy
  task automatic send_cmd(input spi_cmd_t cmd, input logic poke_busy);
    while (!cmd_rdy) @(negedge clk);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    if (poke_busy)
    begin
      repeat ($urandom_range(2, 60)) @(negedge clk);
      cmd_in  = make_cmd(1'b1, int'($urandom_range(0, 7)), 8'($urandom));
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
    end
    while (!cmd_rdy) @(negedge clk);
    repeat ($urandom_range(0, 6)) @(negedge clk);
  endtask

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles)
    begin
      $display("run did not finish within %0d cycles, errors: %0d", timeout_cycles, error_cnt);
      $display("Test failed");
      $finish;
    end
  end

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      sclk_prev <= spi.sclk;
      cs_prev   <= spi.cs_n;
      if (cmd_vld && cmd_rdy)
      begin
        accepted_cnt++;
        cur_write  <= cmd_in.write;
        busy_cnt   <= 0;
        busy_track <= 1'b1;
        if (cmd_in.write)
        begin
          shadow[cmd_in.addr]  <= cmd_in.data;
          written[cmd_in.addr] <= 1'b1;
        end
        else
        begin
          read_accepted_cnt++;
          read_pending <= 1'b1;
          exp_byte = written[cmd_in.addr] ? shadow[cmd_in.addr] : reset_pattern(cmd_in.addr);
          exp_name = written[cmd_in.addr] ? "read_back" : "reset_pattern";
          expect_q.push_back(exp_byte);
          name_q.push_back(exp_name);
        end
      end
      else if (busy_track)
      begin
        if (cmd_rdy)
        begin
          busy_track <= 1'b0;
        end
        else
        begin
          assert (busy_cnt != ready_limit)
          else note_failure("cmd_rdy did not return within 211 clk of acceptance");
          busy_cnt <= busy_cnt + 1;
        end
      end

      if (read_vld)
      begin
        read_vld_cnt++;
        read_pending <= 1'b0;
        if (expect_q.size() > 0)
        begin
          exp_byte = expect_q.pop_front();
          exp_name = name_q.pop_front();
          reads_checked++;
          assert (read_data == exp_byte)
          else report_mismatch(exp_name, exp_byte, read_data);
        end
      end

      if (!spi.cs_n && cs_prev)
      begin
        cs_fall_cnt++;
        sclk_rise_cnt = 0;
      end
      else if (spi.cs_n && !cs_prev)
      begin
        assert (sclk_rise_cnt == (cur_write ? cmd_width : cmd_width + read_width))
        else report_mismatch("sclk_rises", cur_write ? cmd_width : cmd_width + read_width,
                             sclk_rise_cnt);
      end
      else if (spi.sclk && !sclk_prev && !spi.cs_n)
      begin
        sclk_rise_cnt++;
      end
    end
  end

  // the first edge comes before the async reset has settled the outputs
  reset_outputs: assert property (@(posedge clk) (!rst_n && cycle_cnt > 0) |->
    (spi.cs_n && !spi.sclk && !spi.mosi && cmd_rdy && !read_vld))
    else note_failure("outputs not in their reset state while rst_n is low");

  sclk_inside_select: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(spi.sclk) |-> !spi.cs_n)
    else note_failure("sclk toggled while cs_n was high");

  mosi_stable_at_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(spi.sclk) |-> $stable(spi.mosi))
    else note_failure("mosi changed on a rising sclk edge");

  read_vld_expected: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> read_pending)
    else note_failure("read_vld pulsed with no read command outstanding");

  initial
  begin
    void'($urandom(32'h1430c694));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (spi.cs_n && !spi.sclk && !spi.mosi && cmd_rdy && !read_vld && read_data == '0)
    else note_failure("outputs not in their reset state right after reset");

    for (int a = 0; a < reg_count; a++)
    begin
      send_cmd(make_cmd(1'b0, a, 8'h00), 1'b0);
    end
    for (int a = 0; a < reg_count; a++)
    begin
      send_cmd(make_cmd(1'b1, a, 8'($urandom)), 1'b0);
    end
    // stray strobes land while the master is busy and must be dropped
    for (int n = 0; n < num_random; n++)
    begin
      send_cmd(make_cmd(1'($urandom_range(0, 1)), int'($urandom_range(0, 7)), 8'($urandom)),
               1'b1);
    end
    repeat (10) @(negedge clk);

    assert (accepted_cnt == 2 * reg_count + num_random)
    else report_mismatch("accepted_cmds", 2 * reg_count + num_random, accepted_cnt);
    assert (cs_fall_cnt == accepted_cnt)
    else report_mismatch("cs_n_falls", accepted_cnt, cs_fall_cnt);
    assert (read_vld_cnt == read_accepted_cnt)
    else report_mismatch("read_vld_count", read_accepted_cnt, read_vld_cnt);
    for (int a = 0; a < reg_count; a++)
    begin
      exp_byte = written[a] ? shadow[a] : reset_pattern(a);
      assert (spi_reg_device_inst.regs[a] == exp_byte)
      else report_mismatch("reg_contents", exp_byte, spi_reg_device_inst.regs[a]);
    end

    $display("reads checked: %0d, errors: %0d", reads_checked, error_cnt);
    if (error_cnt == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
logic/spi_pkg.sv
logic/spi_sclk_gen.sv
logic/spi_xfer_ctrl.sv
logic/spi_cmd_master.sv
testbench/spi_reg_device.sv
testbench/tb_spi_cmd_master.sv

/* run_sim.sh */
#!/bin/sh
# builds the SPI command master testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_spi_cmd_master -Mdir obj_dir -o tb_sim -f vlog.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation passed"
exit 0
